// ==== common/gem_pkg.sv ====
package gem_pkg;

  // ----------------------------------------------------------------------
  // link word and cluster geometry
  // ----------------------------------------------------------------------
  localparam int n_clst          = 4;    // clusters per link word
  localparam int clst_bits       = 14;   // 3 bit size + 11 bit strip address
  localparam int link_bits       = 56;   // n_clst * clst_bits
  localparam int n_feb           = 24;   // front-end boards per chamber
  localparam int n_roll          = 8;    // eta partitions
  localparam int n_vfat_per_roll = 3;
  localparam int pad_per_vfat    = 64;
  localparam int invalid_feb     = 24;   // feb code for a cluster outside the chamber
  localparam int invalid_pad     = 192;  // one past the last pad in a roll

  // ----------------------------------------------------------------------
  // storage and injector sizes
  // ----------------------------------------------------------------------
  localparam int raw_adr_bits    = 11;   // 2048 deep raw hits store
  localparam int inj_adr_bits    = 10;   // 1024 deep injector rams
  localparam int inj_data_bits   = 16;
  localparam int tbin_bits       = 12;   // run length counter, wraps the ram
  localparam int gem_id          = 0;    // chamber id matched against inj_wr.igem

  typedef struct packed {
    logic [2:0]  cnt;                    // cluster size
    logic [10:0] adr;                    // strip address, vfat id in [10:6]
  } cluster_t;

  typedef struct packed {
    logic       vpf;                     // valid pattern flag
    logic [4:0] feb;
    logic [2:0] roll;
    logic [7:0] pad;                     // pad within the roll
  } cluster_info_t;

  typedef struct packed {
    logic [inj_adr_bits-1:0]  adr;       // injector word address (time bin)
    logic [1:0]               sel;       // which of the four cluster rams
    logic [1:0]               igem;      // target chamber
    logic [inj_data_bits-1:0] data;
    logic                     wen;       // level, rising edge writes
  } inj_wr_t;

  typedef enum logic {
    inj_pass,                            // clusters come from the link
    inj_running                          // clusters come from the injector rams
  } inj_state_t;

endpackage

// ==== rtl/cluster_decode.sv ====
`timescale 1ns/10ps

module cluster_decode (
  input  gem_pkg::cluster_t      clst,  // selected cluster
  output gem_pkg::cluster_info_t info   // valid flag and chamber coordinates
);

  logic [4:0] vfat;      // natural vfat id
  logic [4:0] vfat_div;  // vfat / 3
  logic [4:0] vfat_mod;  // vfat % 3
  logic [2:0] roll;      // eta partition of this vfat
  logic [1:0] grp;       // vfat position across the roll, 0..2

  // vfats are numbered roll by roll, three per roll, so
  // the board number interleaves rolls in steps of eight
  always_comb begin
    vfat     = clst.adr[10:6];
    vfat_div = vfat / 5'(gem_pkg::n_vfat_per_roll);
    vfat_mod = vfat % 5'(gem_pkg::n_vfat_per_roll);
    roll     = vfat_div[2:0];
    grp      = vfat_mod[1:0];

    info.vpf = ~&clst.adr[10:9];        // top two address bits set means no cluster

    if (vfat < 5'(gem_pkg::n_roll * gem_pkg::n_vfat_per_roll)) begin
      info.roll = roll;
      info.feb  = 5'(roll) + 5'(grp) * 5'(gem_pkg::n_roll);  // 0..7, 8..15, 16..23
      info.pad  = 8'(grp) * 8'(gem_pkg::pad_per_vfat)       // vfat offset in the roll
                + 8'(clst.adr[5:0]);                         // strip pair within vfat
    end else begin
      info.roll = '0;                                        // out of chamber
      info.feb  = 5'(gem_pkg::invalid_feb);
      info.pad  = 8'(gem_pkg::invalid_pad);
    end
  end

endmodule

// ==== injector/inj_ctrl.sv ====
`timescale 1ns/10ps

module inj_ctrl (
  input  logic                             clock,
  input  logic                             sm_reset,
  input  logic                             inj_go,         // start pulse, ignored mid run
  input  logic [gem_pkg::tbin_bits-1:0]    inj_last_tbin,  // last time bin of the run
  output logic [gem_pkg::inj_adr_bits-1:0] tbin_adr,       // injector ram read address
  output logic                             pass            // 1 = link data, 0 = injected
);

  gem_pkg::inj_state_t           state;
  logic [gem_pkg::tbin_bits-1:0] tbin_cnt;   // time bin within the run
  logic                          tbin_done;  // last bin reached

  assign tbin_done = (tbin_cnt == inj_last_tbin);
  assign tbin_adr  = tbin_cnt[gem_pkg::inj_adr_bits-1:0];  // long runs wrap the ram

  // ----------------------------------------------------------------------
  // run state machine
  // ----------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (sm_reset) begin
      state <= gem_pkg::inj_pass;
    end else begin
      case (state)
        gem_pkg::inj_pass: begin
          if (inj_go) begin
            state <= gem_pkg::inj_running;
          end
        end
        gem_pkg::inj_running: begin
          if (tbin_done) begin
            state <= gem_pkg::inj_pass;
          end
        end
        default: state <= gem_pkg::inj_pass;
      endcase
    end
  end

  // counter held at zero while passing, so a run always starts at bin 0
  always_ff @(posedge clock) begin
    if (sm_reset || state == gem_pkg::inj_pass) begin
      tbin_cnt <= '0;
    end else begin
      tbin_cnt <= tbin_cnt + 1'b1;
    end
  end

  // one cycle behind the state, lines up with the ram read latency
  always_ff @(posedge clock) begin
    if (sm_reset) begin
      pass <= 1'b1;
    end else begin
      pass <= (state == gem_pkg::inj_pass);
    end
  end

endmodule

// ==== injector/inj_ram.sv ====
`timescale 1ns/10ps

module inj_ram (
  input  logic                                        clock,
  input  gem_pkg::inj_wr_t                            inj_wr,       // write port, wen is a level
  input  logic [gem_pkg::inj_adr_bits-1:0]            tbin_adr,     // read address from inj_ctrl
  output gem_pkg::cluster_t [gem_pkg::n_clst-1:0]     inj_clusters  // one word per ram, 1 clk late
);

  logic wen_ff = 1'b0;  // wen delayed one clock
  logic wen_os;         // first cycle of wen
  logic id_match;       // write is meant for this chamber

  always_ff @(posedge clock) begin
    wen_ff <= inj_wr.wen;
  end

  assign wen_os   = inj_wr.wen & ~wen_ff;
  assign id_match = (inj_wr.igem == 2'(gem_pkg::gem_id));

  // ----------------------------------------------------------------------
  // one ram per cluster slot
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < gem_pkg::n_clst; i++) begin : g_ram
    logic [gem_pkg::inj_data_bits-1:0] mem [2**gem_pkg::inj_adr_bits];
    logic                              ram_wen;  // sel points at this ram
    gem_pkg::cluster_t                 rd_q;     // read register

    // all ones reads back as an invalid cluster
    initial begin
      for (int a = 0; a < 2**gem_pkg::inj_adr_bits; a++) begin
        mem[a] = '1;
      end
    end

    assign ram_wen = wen_os && id_match && (inj_wr.sel == 2'(i));

    always_ff @(posedge clock) begin
      if (ram_wen) begin
        mem[inj_wr.adr] <= inj_wr.data;
      end
      rd_q <= mem[tbin_adr][gem_pkg::clst_bits-1:0];  // upper two bits carry no cluster data
    end

    assign inj_clusters[i] = rd_q;
  end

endmodule

// ==== raw_hits/raw_hits_ram.sv ====
`timescale 1ns/10ps

module raw_hits_ram (
  input  logic                                    clock,
  input  gem_pkg::cluster_t [gem_pkg::n_clst-1:0] clst,        // clusters to store
  input  logic                                    wen,         // write this bx
  input  logic [gem_pkg::raw_adr_bits-1:0]        wadr,
  input  logic [gem_pkg::raw_adr_bits-1:0]        radr,
  input  logic [$clog2(gem_pkg::n_clst)-1:0]      sel,         // cluster slot to read out
  output gem_pkg::cluster_t                       rdata,       // selected cluster, 1 clk after radr
  output logic [gem_pkg::n_clst-1:0]              parity_err   // per slot, either half bad
);

  gem_pkg::cluster_t [gem_pkg::n_clst-1:0] rd_clst;  // read data with parity stripped

  // ----------------------------------------------------------------------
  // word layout  {par_hi, data[13:7], par_lo, data[6:0]}
  // odd parity, so an all zero word also shows up as an error
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < gem_pkg::n_clst; i++) begin : g_slot
    logic [15:0] mem [2**gem_pkg::raw_adr_bits];
    logic [15:0] wr_word;
    logic [15:0] rd_q;
    logic [6:0]  wr_lo;   // lower half of the cluster
    logic [6:0]  wr_hi;   // upper half
    logic [6:0]  rd_lo;
    logic [6:0]  rd_hi;
    logic        err_lo;
    logic        err_hi;

    assign wr_lo   = clst[i][6:0];
    assign wr_hi   = clst[i][13:7];
    assign wr_word = {~^wr_hi, wr_hi, ~^wr_lo, wr_lo};

    always_ff @(posedge clock) begin
      if (wen) begin
        mem[wadr] <= wr_word;
      end
      rd_q <= mem[radr];
    end

    assign rd_lo  = rd_q[6:0];
    assign rd_hi  = rd_q[14:8];
    assign err_lo = (rd_q[7] != ~^rd_lo);   // stored vs recomputed
    assign err_hi = (rd_q[15] != ~^rd_hi);

    assign rd_clst[i]    = {rd_hi, rd_lo};
    assign parity_err[i] = err_lo | err_hi;
  end

  assign rdata = rd_clst[sel];  // slot mux after the read register

endmodule

// ==== rtl/gem_trig.sv ====
`timescale 1ns/10ps

module gem_trig (
  input  logic                                        clock,
  input  logic                                        sm_reset,

  input  logic [gem_pkg::link_bits-1:0]               link_data,        // four clusters per bx

  input  gem_pkg::inj_wr_t                            inj_wr,           // injector ram load
  input  logic                                        inj_go,           // start injection run
  input  logic [gem_pkg::tbin_bits-1:0]               inj_last_tbin,

  input  logic                                        fifo_wen,         // raw hits store write
  input  logic [gem_pkg::raw_adr_bits-1:0]            fifo_wadr,
  input  logic [gem_pkg::raw_adr_bits-1:0]            fifo_radr,
  input  logic [$clog2(gem_pkg::n_clst)-1:0]          fifo_sel,

  output gem_pkg::cluster_t [gem_pkg::n_clst-1:0]     clusters,         // selected source
  output gem_pkg::cluster_info_t [gem_pkg::n_clst-1:0] info,            // decoded clusters
  output logic [gem_pkg::n_feb-1:0]                   active_feb_list,  // febs hit last bx
  output gem_pkg::cluster_t                           fifo_rdata,
  output logic [gem_pkg::n_clst-1:0]                  parity_err
);

  logic                                    pass;          // 1 = link, 0 = injector
  logic [gem_pkg::inj_adr_bits-1:0]        inj_tbin_adr;  // injector read address
  gem_pkg::cluster_t [gem_pkg::n_clst-1:0] link_clst;     // clusters unpacked from the link
  gem_pkg::cluster_t [gem_pkg::n_clst-1:0] inj_clst;      // clusters from the injector rams
  logic [gem_pkg::n_feb-1:0]               feb_hit;       // next active feb list

  // ----------------------------------------------------------------------
  // injector
  // ----------------------------------------------------------------------
  inj_ctrl u_inj_ctrl (
    .clock         (clock),
    .sm_reset      (sm_reset),
    .inj_go        (inj_go),
    .inj_last_tbin (inj_last_tbin),
    .tbin_adr      (inj_tbin_adr),
    .pass          (pass)
  );

  inj_ram u_inj_ram (
    .clock        (clock),
    .inj_wr       (inj_wr),
    .tbin_adr     (inj_tbin_adr),
    .inj_clusters (inj_clst)
  );

  // ----------------------------------------------------------------------
  // source select and decode
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < gem_pkg::n_clst; i++) begin : g_clst
    assign link_clst[i] = link_data[i*gem_pkg::clst_bits +: gem_pkg::clst_bits];
    assign clusters[i]  = pass ? link_clst[i] : inj_clst[i];

    cluster_decode u_decode (
      .clst (clusters[i]),
      .info (info[i])
    );
  end

  // feb f is active when any valid cluster lands on it
  always_comb begin
    feb_hit = '0;
    for (int f = 0; f < gem_pkg::n_feb; f++) begin
      for (int c = 0; c < gem_pkg::n_clst; c++) begin
        feb_hit[f] = feb_hit[f] | (info[c].vpf && info[c].feb == 5'(f));
      end
    end
  end

  always_ff @(posedge clock) begin
    if (sm_reset) begin
      active_feb_list <= '0;
    end else begin
      active_feb_list <= feb_hit;  // usable for a chamber self trigger
    end
  end

  // ----------------------------------------------------------------------
  // raw hits store
  // ----------------------------------------------------------------------
  raw_hits_ram u_raw_hits_ram (
    .clock      (clock),
    .clst       (clusters),
    .wen        (fifo_wen),
    .wadr       (fifo_wadr),
    .radr       (fifo_radr),
    .sel        (fifo_sel),
    .rdata      (fifo_rdata),
    .parity_err (parity_err)
  );

endmodule

// ==== dv/gem_trig_assert.sv ====
`timescale 1ns/10ps

module gem_trig_assert (
  input logic                                         clock,
  input logic                                         sm_reset,
  input logic [gem_pkg::link_bits-1:0]                link_data,
  input gem_pkg::inj_wr_t                             inj_wr,
  input logic                                         inj_go,
  input logic [gem_pkg::tbin_bits-1:0]                inj_last_tbin,
  input logic                                         pass,        // internal source flag
  input logic                                         fifo_wen,
  input logic [gem_pkg::raw_adr_bits-1:0]             fifo_wadr,
  input logic [gem_pkg::raw_adr_bits-1:0]             fifo_radr,
  input logic [$clog2(gem_pkg::n_clst)-1:0]           fifo_sel,
  input gem_pkg::cluster_t [gem_pkg::n_clst-1:0]      clusters,
  input gem_pkg::cluster_info_t [gem_pkg::n_clst-1:0] info,
  input logic [gem_pkg::n_feb-1:0]                    active_feb_list,
  input gem_pkg::cluster_t                            fifo_rdata,
  input logic [gem_pkg::n_clst-1:0]                   parity_err
);

  int                                       fail_cnt = 0;  // read by the testbench
  logic [15:0]                              inj_shadow [4][1024];
  logic [3:0][1023:0]                       inj_written;   // shadow word loaded
  logic                                     wen_q;         // previous wen level
  logic [12:0]                              win_cnt;       // cycles spent in the window
  gem_pkg::cluster_t [3:0]                  raw_shadow [2048];
  logic [2047:0]                            raw_valid;
  gem_pkg::cluster_t [3:0]                  raw_exp_q;     // expected read data
  logic                                     raw_valid_q;
  gem_pkg::cluster_info_t [gem_pkg::n_clst-1:0] exp_info;
  gem_pkg::cluster_t [gem_pkg::n_clst-1:0]  exp_inj;       // word k of each injector ram
  logic [gem_pkg::n_feb-1:0]                exp_feb;

  // ----------------------------------------------------------------------
  // reference models for injector ram, window and raw hits store
  // ----------------------------------------------------------------------
  always @(posedge clock) begin
    wen_q <= inj_wr.wen;
    if (sm_reset) begin
      inj_written <= '0;
      raw_valid   <= '0;
      raw_valid_q <= 1'b0;
      win_cnt     <= '0;
    end else begin
      if (inj_wr.wen && !wen_q && inj_wr.igem == 2'(gem_pkg::gem_id)) begin  // first cycle only
        inj_shadow[inj_wr.sel][inj_wr.adr]  <= inj_wr.data;
        inj_written[inj_wr.sel][inj_wr.adr] <= 1'b1;
      end
      if (fifo_wen) begin
        raw_shadow[fifo_wadr] <= clusters;
        raw_valid[fifo_wadr]  <= 1'b1;
      end
      raw_exp_q   <= raw_shadow[fifo_radr];  // old word on a same-edge write
      raw_valid_q <= raw_valid[fifo_radr];
      win_cnt     <= pass ? 13'd0 : win_cnt + 13'd1;
    end
  end

  always_comb begin
    int vfat;
    int grp;
    exp_feb = '0;
    for (int c = 0; c < gem_pkg::n_clst; c++) begin
      vfat = int'(clusters[c].adr[10:6]);
      grp  = vfat % 3;                                          // vfat position in the roll
      exp_info[c].vpf = !(clusters[c].adr[10] && clusters[c].adr[9]);
      if (vfat < 24) begin
        exp_info[c].roll = 3'(vfat / 3);
        exp_info[c].feb  = 5'(vfat / 3 + 8 * grp);
        exp_info[c].pad  = 8'(64 * grp + int'(clusters[c].adr[5:0]));
      end else begin
        exp_info[c].roll = 3'd0;
        exp_info[c].feb  = 5'd24;
        exp_info[c].pad  = 8'd192;
      end
      if (exp_info[c].vpf && exp_info[c].feb < 5'd24) begin
        exp_feb[exp_info[c].feb] = 1'b1;
      end
      exp_inj[c] = inj_written[c][win_cnt[9:0]] ? inj_shadow[c][win_cnt[9:0]][13:0] : '1;
    end
  end

  // ----------------------------------------------------------------------
  // properties
  // ----------------------------------------------------------------------
  a_reset: assert property (@(posedge clock) disable iff (sm_reset)
    $past(sm_reset) |-> pass && active_feb_list == '0)
    else begin fail_cnt++; $error("error at %0t: state after reset is wrong", $time); end

  a_link: assert property (@(posedge clock) disable iff (sm_reset)
    pass |-> clusters == link_data)
    else begin fail_cnt++; $error("error at %0t: clusters differ from link", $time); end

  a_decode: assert property (@(posedge clock) disable iff (sm_reset)
    info == exp_info)
    else begin fail_cnt++; $error("error at %0t: decoded info is wrong", $time); end

  a_feb: assert property (@(posedge clock) disable iff (sm_reset)
    !$past(sm_reset) |-> active_feb_list == $past(exp_feb))
    else begin fail_cnt++; $error("error at %0t: active feb list is wrong", $time); end

  a_start: assert property (@(posedge clock) disable iff (sm_reset)
    pass && inj_go && !$past(inj_go) |-> ##2 !pass)
    else begin fail_cnt++; $error("error at %0t: injection did not start", $time); end

  a_inj: assert property (@(posedge clock) disable iff (sm_reset)
    !pass |-> clusters == exp_inj && win_cnt <= {1'b0, inj_last_tbin})
    else begin fail_cnt++; $error("error at %0t: injected cluster is wrong", $time); end

  a_len: assert property (@(posedge clock) disable iff (sm_reset)
    !$past(sm_reset) && $rose(pass) |-> win_cnt == {1'b0, inj_last_tbin} + 13'd1)
    else begin fail_cnt++; $error("error at %0t: injection window length", $time); end

  a_raw: assert property (@(posedge clock) disable iff (sm_reset)
    raw_valid_q |-> fifo_rdata == raw_exp_q[fifo_sel] && parity_err == '0)
    else begin fail_cnt++; $error("error at %0t: raw hits readback is wrong", $time); end

endmodule

// ==== dv/gem_trig_tb.sv ====
`timescale 1ns/10ps

module gem_trig_tb;

  logic                                        clock;
  logic                                        sm_reset;
  logic [gem_pkg::link_bits-1:0]               link_data;
  gem_pkg::inj_wr_t                            inj_wr;
  logic                                        inj_go;
  logic [gem_pkg::tbin_bits-1:0]               inj_last_tbin;
  logic                                        fifo_wen;
  logic [gem_pkg::raw_adr_bits-1:0]            fifo_wadr;
  logic [gem_pkg::raw_adr_bits-1:0]            fifo_radr;
  logic [1:0]                                  fifo_sel;
  gem_pkg::cluster_t [gem_pkg::n_clst-1:0]     clusters;
  gem_pkg::cluster_info_t [gem_pkg::n_clst-1:0] info;
  logic [gem_pkg::n_feb-1:0]                   active_feb_list;
  gem_pkg::cluster_t                           fifo_rdata;
  logic [gem_pkg::n_clst-1:0]                  parity_err;

  int          tests_failed = 0;
  int          fails_before = 0;  // checker count at the start of a test
  logic [10:0] raw_adr [16];      // addresses written in the raw hits test

  gem_trig gem_trig_i (.*);

  bind gem_trig gem_trig_assert u_chk (
    .clock(clock), .sm_reset(sm_reset), .link_data(link_data), .inj_wr(inj_wr),
    .inj_go(inj_go), .inj_last_tbin(inj_last_tbin), .pass(pass), .fifo_wen(fifo_wen),
    .fifo_wadr(fifo_wadr), .fifo_radr(fifo_radr), .fifo_sel(fifo_sel),
    .clusters(clusters), .info(info), .active_feb_list(active_feb_list),
    .fifo_rdata(fifo_rdata), .parity_err(parity_err)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;  // 100 ns period
  end

  task automatic report_test(input string name);
    int errs;
    errs = gem_trig_i.u_chk.fail_cnt - fails_before;
    if (errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d assertion failures", name, errs);
    end
    fails_before = gem_trig_i.u_chk.fail_cnt;
  endtask

  // sampled on the falling edge, away from the register updates
  task automatic wait_pass(input logic level, input int limit);
    int n;
    n = 0;
    while (gem_trig_i.pass !== level && n < limit) begin
      @(negedge clock);
      n++;
    end
    if (gem_trig_i.pass !== level) begin
      $display("timeout while waiting for the injector pass flag to reach %0b", level);
      $display("Simulation FAILED");
      $finish;
    end
  endtask

  task automatic load_inj(input int adr, input int sel, input int igem, input int data);
    @(posedge clock);
    inj_wr.adr  <= 10'(adr);
    inj_wr.sel  <= 2'(sel);
    inj_wr.igem <= 2'(igem);
    inj_wr.data <= 16'(data);
    inj_wr.wen  <= 1'b1;
    @(posedge clock);
    inj_wr.wen  <= 1'b0;  // rising edge only, so drop it between words
  endtask

  initial begin
    void'($urandom(32'h8439_421b));
    sm_reset      = 1'b1;
    link_data     = '0;
    inj_wr        = '0;
    inj_go        = 1'b0;
    inj_last_tbin = 12'd5;
    fifo_wen      = 1'b0;
    fifo_wadr     = '0;
    fifo_radr     = '0;
    fifo_sel      = '0;
    repeat (2) @(posedge clock);
    sm_reset <= 1'b0;

    repeat (4) begin
      @(posedge clock);
      link_data <= 56'({$urandom(), $urandom()});
    end
    report_test("reset");

    repeat (200) begin  // about a quarter of the clusters land out of the chamber
      @(posedge clock);
      link_data <= 56'({$urandom(), $urandom()});
    end
    report_test("decode");

    repeat (50) begin
      @(posedge clock);
      link_data <= {{3{14'h3fff}}, 14'($urandom())};  // single hit, the rest invalid
    end
    report_test("active_feb_list");

    for (int k = 0; k <= 5; k++) begin
      for (int s = 0; s < 4; s++) begin
        load_inj(k, s, gem_pkg::gem_id, int'($urandom()));
      end
    end
    load_inj(0, 0, 1, 0);  // other chamber, must not land
    @(posedge clock);
    inj_go <= 1'b1;
    @(posedge clock);
    inj_go <= 1'b0;
    wait_pass(1'b0, 10);
    wait_pass(1'b1, 20);
    repeat (3) @(posedge clock);
    report_test("injection");

    for (int n = 0; n < 16; n++) begin
      raw_adr[n] = 11'($urandom());
      @(posedge clock);
      link_data <= 56'({$urandom(), $urandom()});
      fifo_wen  <= 1'b1;
      fifo_wadr <= raw_adr[n];
    end
    @(posedge clock);
    fifo_wen <= 1'b0;
    for (int n = 0; n < 16; n++) begin
      for (int s = 0; s < 4; s++) begin
        @(posedge clock);
        fifo_radr <= raw_adr[n];
        fifo_sel  <= 2'(s);
      end
    end
    repeat (3) @(posedge clock);
    report_test("raw_hits");

    $display("tests failed %0d of 5, assertion errors %0d",
             tests_failed, gem_trig_i.u_chk.fail_cnt);
    if (tests_failed == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== gem_trig.f ====
common/gem_pkg.sv
rtl/cluster_decode.sv
injector/inj_ctrl.sv
injector/inj_ram.sv
raw_hits/raw_hits_ram.sv
rtl/gem_trig.sv
dv/gem_trig_assert.sv
dv/gem_trig_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the gem_trig testbench with verilator, run it, look for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module gem_trig_tb -f gem_trig.f
out=$(./obj_dir/Vgem_trig_tb +verilator+error+limit+1000) || true
echo "$out"
if echo "$out" | grep -q "Simulation PASSED"; then
  exit 0
else
  exit 1
fi
